// File: hw/boot_link_pkg.sv
/* GPIO link protocol: request packet, read word layout, register select,
   frame markers and command words */
`default_nettype none

package boot_link_pkg;

    // GPIO register selected by a request
    typedef enum logic [5:0] {
        GPIO_ODATA = 6'h00,
        GPIO_IDATA = 6'h05
    } gpio_data_type_e;

    typedef struct packed {
        logic            access;
        logic            rw;       // High for a write
        gpio_data_type_e data_type;
        logic [31:0]     wr_data;
    } gpio_req_t;

    // Read register as seen from the controller
    typedef struct packed {
        logic [15:0] data;
        logic [1:0]  rsvd_hi;
        logic        strobe;       // One new word per cycle
        logic [4:0]  rsvd_mid;
        logic        wake_ack;
        logic [6:0]  rsvd_lo;
    } gpio_rword_t;

    localparam logic [15:0] FRAME_HEADER  = 16'h7A7A;
    localparam logic [15:0] FRAME_TRAILER = 16'hB9B9;
    localparam logic [31:0] WAKE_CMD      = 32'h0000_0040;
    localparam int          TRIGGER_BIT   = 12;  // ID index sits just below

endpackage

`default_nettype wire

// File: hw/boot_id_pkg.sv
/* Chip identity widths, memory slots, SHA and memory request structs,
   boot sequencer states */
`default_nettype none

package boot_id_pkg;

    localparam int ID_W         = 256;
    localparam int WORDS_PER_ID = 16;
    localparam int MEM_ADDR_W   = 3;

    typedef enum logic [MEM_ADDR_W-1:0] {
        MCSE_ID_SLOT = 3'd0,
        IP_ID_SLOT   = 3'd1
    } mem_slot_e;

    typedef struct packed {
        logic                  wr_en;
        logic [MEM_ADDR_W-1:0] addr;
        logic [ID_W-1:0]       data;
    } mem_wr_t;

    typedef struct packed {
        logic              init;
        logic              next;
        logic [2*ID_W-1:0] block;  // Upper half is the higher ID
    } sha_req_t;

    typedef enum logic [3:0] {
        BOOT_INIT, MCSE_GEN, MCSE_STORE, BUS_WAKE, WAKE_WAIT,
        IPID_TRIGGER, IPID_RECEIVE, IPID_HASH, IPID_STORE, BOOT_DONE
    } boot_state_e;

endpackage

`default_nettype wire

// File: hw/ipid_frame_decoder.sv
/* IP ID frame decoder: header, payload and trailer parsing of GPIO words,
   ID buffer with pair read port */
`timescale 1ns/10ps
`default_nettype none

module ipid_frame_decoder
    import boot_link_pkg::*;
    import boot_id_pkg::*;
#(
    parameter int IPID_COUNT = 16,
    localparam int IDX_W = $clog2(IPID_COUNT),
    localparam int PAIR_W = IDX_W - 1
) (
    input  logic                clk,
    input  logic                rst,
    input  gpio_rword_t         gpio_rdata,
    input  logic                listen,
    input  logic [IDX_W-1:0]    id_index,
    output logic                frame_ok,
    output logic                frame_bad,
    input  logic [PAIR_W-1:0]   pair_sel,
    output logic [2*ID_W-1:0]   pair_block
);

    localparam int WORD_W = ID_W / WORDS_PER_ID;
    localparam int CNT_W  = $clog2(WORDS_PER_ID);

    typedef enum logic [1:0] {PH_HEADER, PH_PAYLOAD, PH_TRAILER} frame_phase_e;

    frame_phase_e       phase;
    logic [CNT_W-1:0]   word_cnt;
    logic               word_vld;
    logic [ID_W-1:0]    id_buf [IPID_COUNT];

    assign word_vld = listen && gpio_rdata.strobe;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase     <= PH_HEADER;
            word_cnt  <= '0;
            frame_ok  <= 1'b0;
            frame_bad <= 1'b0;
        end else begin
            frame_ok  <= 1'b0;
            frame_bad <= 1'b0;
            if (!listen) begin
                phase    <= PH_HEADER;
                word_cnt <= '0;
            end else if (gpio_rdata.strobe) begin
                case (phase)
                    PH_HEADER: begin
                        if (gpio_rdata.data == FRAME_HEADER) phase <= PH_PAYLOAD;
                    end
                    PH_PAYLOAD: begin
                        word_cnt <= word_cnt + 1'b1;  // Wraps to zero on the last word
                        if (word_cnt == CNT_W'(WORDS_PER_ID - 1)) phase <= PH_TRAILER;
                    end
                    PH_TRAILER: begin
                        frame_ok  <= (gpio_rdata.data == FRAME_TRAILER);
                        frame_bad <= (gpio_rdata.data != FRAME_TRAILER);
                        phase     <= PH_HEADER;
                    end
                    default: phase <= PH_HEADER;
                endcase
            end
        end
    end

    // Most significant word arrives first
    always_ff @(posedge clk) begin
        if (word_vld && phase == PH_PAYLOAD) begin
            id_buf[id_index] <= {id_buf[id_index][ID_W-WORD_W-1:0], gpio_rdata.data};
        end
    end

    assign pair_block = {id_buf[{pair_sel, 1'b1}], id_buf[{pair_sel, 1'b0}]};

    // Target slot must not move while a frame is open
    a_index_steady: assert property (@(posedge clk) disable iff (!rst)
        (listen && phase != PH_HEADER) |=> $stable(id_index));

endmodule

`default_nettype wire

// File: hw/ipid_hash_engine.sv
/* IP ID hash engine: feeds ID pairs to the SHA core with init/next strobes
   and captures the final digest */
`timescale 1ns/10ps
`default_nettype none

module ipid_hash_engine
    import boot_id_pkg::*;
#(
    parameter int IPID_COUNT = 16,
    localparam int PAIR_W = $clog2(IPID_COUNT) - 1
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                hash_start,
    input  logic [2*ID_W-1:0]   pair_block,
    output logic [PAIR_W-1:0]   pair_sel,
    output sha_req_t            sha_req,
    input  logic                sha_ready,
    input  logic [ID_W-1:0]     sha_digest,
    output logic [ID_W-1:0]     digest,
    output logic                hash_done
);

    typedef enum logic [2:0] {H_IDLE, H_LOAD, H_STROBE, H_GAP, H_WAIT} hash_phase_e;

    hash_phase_e        phase;
    logic [2*ID_W-1:0]  block_q;
    logic               init_q;
    logic               next_q;
    logic               last_pair;

    assign last_pair = (pair_sel == PAIR_W'(IPID_COUNT / 2 - 1));
    assign sha_req   = '{init: init_q, next: next_q, block: block_q};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase     <= H_IDLE;
            pair_sel  <= '0;
            init_q    <= 1'b0;
            next_q    <= 1'b0;
            hash_done <= 1'b0;
        end else begin
            hash_done <= 1'b0;
            case (phase)
                H_IDLE: begin
                    if (hash_start) begin
                        pair_sel <= '0;
                        phase    <= H_LOAD;
                    end
                end
                H_LOAD: begin
                    init_q <= (pair_sel == '0);  // First block starts a new hash
                    next_q <= (pair_sel != '0);
                    phase  <= H_STROBE;
                end
                H_STROBE: begin
                    init_q <= 1'b0;
                    next_q <= 1'b0;
                    phase  <= H_GAP;
                end
                H_GAP: phase <= H_WAIT;  // Core drops ready here
                H_WAIT: begin
                    if (sha_ready && last_pair) begin
                        hash_done <= 1'b1;
                        phase     <= H_IDLE;
                    end else if (sha_ready) begin
                        pair_sel <= pair_sel + 1'b1;
                        phase    <= H_LOAD;
                    end
                end
                default: phase <= H_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == H_LOAD) block_q <= pair_block;
        if (phase == H_WAIT && sha_ready && last_pair) digest <= sha_digest;
    end

    // A start while busy would be lost
    a_start_idle: assert property (@(posedge clk) disable iff (!rst)
        hash_start |-> phase == H_IDLE);

endmodule

`default_nettype wire

// File: hw/id_store_writer.sv
/* Secure memory writer: one-cycle write of a slot, then a done pulse */
`timescale 1ns/10ps
`default_nettype none

module id_store_writer
    import boot_id_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            store_req,
    input  mem_slot_e       store_slot,
    input  logic [ID_W-1:0] store_data,
    output logic            store_done,
    output mem_wr_t         mem_wr
);

    logic                  wr_en_q;
    logic [MEM_ADDR_W-1:0] addr_q;
    logic [ID_W-1:0]       data_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_en_q    <= 1'b0;
            store_done <= 1'b0;
        end else begin
            wr_en_q    <= store_req;
            store_done <= wr_en_q;  // Write has landed
        end
    end

    always_ff @(posedge clk) begin
        if (store_req) begin
            addr_q <= store_slot;
            data_q <= store_data;
        end
    end

    assign mem_wr = '{wr_en: wr_en_q, addr: addr_q, data: data_q};

    // Holds only while requests stay single pulses
    a_wr_single: assert property (@(posedge clk) disable iff (!rst)
        mem_wr.wr_en |=> !mem_wr.wr_en);

endmodule

`default_nettype wire

// File: hw/chip_id_sequencer.sv
/* Boot flow FSM: MCSE ID, bus wake, IP ID triggers and receive, hash and
   store ordering, boot_done */
`timescale 1ns/10ps
`default_nettype none

module chip_id_sequencer
    import boot_link_pkg::*;
    import boot_id_pkg::*;
#(
    parameter int IPID_COUNT = 16,
    localparam int IDX_W = $clog2(IPID_COUNT)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [ID_W-1:0]     cam_puf,
    input  logic [ID_W-1:0]     sha_puf,
    input  gpio_rword_t         gpio_rdata,
    output gpio_req_t           gpio_req,
    output logic                listen,
    output logic [IDX_W-1:0]    id_index,
    input  logic                frame_ok,
    input  logic                frame_bad,
    output logic                hash_start,
    input  logic                hash_done,
    input  logic [ID_W-1:0]     digest,
    output logic                store_req,
    output mem_slot_e           store_slot,
    output logic [ID_W-1:0]     store_data,
    input  logic                store_done,
    output logic                boot_done
);

    boot_state_e        state;
    logic [IDX_W-1:0]   id_cnt;
    logic [31:0]        trig_word;

    function automatic gpio_req_t gpio_pkt(input logic rw, input gpio_data_type_e dtype,
                                           input logic [31:0] data);
        return '{access: 1'b1, rw: rw, data_type: dtype, wr_data: data};
    endfunction

    always_comb begin
        trig_word = '0;
        trig_word[TRIGGER_BIT] = 1'b1;
        trig_word[TRIGGER_BIT-1 -: 4] = 4'(id_cnt);
    end

    assign listen   = (state == IPID_RECEIVE);
    assign id_index = id_cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state      <= BOOT_INIT;
            gpio_req   <= '0;
            id_cnt     <= '0;
            hash_start <= 1'b0;
            store_req  <= 1'b0;
            boot_done  <= 1'b0;
        end else begin
            hash_start <= 1'b0;
            store_req  <= 1'b0;
            case (state)
                BOOT_INIT: begin
                    gpio_req <= gpio_pkt(1'b0, GPIO_IDATA, '0);
                    state    <= MCSE_GEN;
                end
                MCSE_GEN: begin
                    store_req <= 1'b1;
                    state     <= MCSE_STORE;
                end
                MCSE_STORE: if (store_done) state <= BUS_WAKE;
                BUS_WAKE: begin
                    gpio_req <= gpio_pkt(1'b1, GPIO_ODATA, WAKE_CMD);
                    state    <= WAKE_WAIT;
                end
                WAKE_WAIT: begin
                    gpio_req <= gpio_pkt(1'b0, GPIO_IDATA, '0);
                    if (gpio_rdata.wake_ack) state <= IPID_TRIGGER;
                end
                IPID_TRIGGER: begin
                    gpio_req <= gpio_pkt(1'b1, GPIO_ODATA, trig_word);
                    state    <= IPID_RECEIVE;
                end
                IPID_RECEIVE: begin
                    gpio_req <= gpio_pkt(1'b0, GPIO_IDATA, '0);
                    if (frame_ok || frame_bad) begin
                        gpio_req <= gpio_pkt(1'b1, GPIO_ODATA, '0);  // Closes the frame
                        state    <= IPID_TRIGGER;  // Bad frame asks again
                    end
                    if (frame_ok && id_cnt == IDX_W'(IPID_COUNT - 1)) begin
                        hash_start <= 1'b1;
                        state      <= IPID_HASH;
                    end else if (frame_ok) begin
                        id_cnt <= id_cnt + 1'b1;
                    end
                end
                IPID_HASH: begin
                    gpio_req <= gpio_pkt(1'b0, GPIO_IDATA, '0);
                    if (hash_done) begin
                        store_req <= 1'b1;
                        state     <= IPID_STORE;
                    end
                end
                IPID_STORE: begin
                    if (store_done) begin
                        boot_done <= 1'b1;
                        state     <= BOOT_DONE;
                    end
                end
                BOOT_DONE: state <= BOOT_DONE;
                default:   state <= BOOT_INIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MCSE_GEN) begin
            store_slot <= MCSE_ID_SLOT;
            store_data <= cam_puf ^ sha_puf;  // MCSE ID
        end else if (state == IPID_HASH && hash_done) begin
            store_slot <= IP_ID_SLOT;
            store_data <= digest;
        end
    end

endmodule

`default_nettype wire

// File: hw/secure_boot_control.sv
/* Secure boot controller top: chip identity sequencer, frame decoder,
   hash engine and memory writer */
`timescale 1ns/10ps
`default_nettype none

module secure_boot_control
    import boot_link_pkg::*;
    import boot_id_pkg::*;
#(
    parameter int IPID_COUNT = 16  // Even, at least 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [ID_W-1:0] cam_puf,
    input  logic [ID_W-1:0] sha_puf,
    input  gpio_rword_t     gpio_rdata,
    output gpio_req_t       gpio_req,
    output sha_req_t        sha_req,
    input  logic            sha_ready,
    input  logic [ID_W-1:0] sha_digest,
    output mem_wr_t         mem_wr,
    output logic            boot_done
);

    localparam int IDX_W  = $clog2(IPID_COUNT);
    localparam int PAIR_W = IDX_W - 1;

    logic               listen;
    logic [IDX_W-1:0]   id_index;
    logic               frame_ok;
    logic               frame_bad;
    logic [PAIR_W-1:0]  pair_sel;
    logic [2*ID_W-1:0]  pair_block;
    logic               hash_start;
    logic               hash_done;
    logic [ID_W-1:0]    digest;
    logic               store_req;
    mem_slot_e          store_slot;
    logic [ID_W-1:0]    store_data;
    logic               store_done;

    chip_id_sequencer #(.IPID_COUNT(IPID_COUNT)) u_chip_id_sequencer (
        .clk(clk), .rst(rst), .cam_puf(cam_puf), .sha_puf(sha_puf),
        .gpio_rdata(gpio_rdata), .gpio_req(gpio_req),
        .listen(listen), .id_index(id_index), .frame_ok(frame_ok), .frame_bad(frame_bad),
        .hash_start(hash_start), .hash_done(hash_done), .digest(digest),
        .store_req(store_req), .store_slot(store_slot), .store_data(store_data),
        .store_done(store_done), .boot_done(boot_done)
    );

    ipid_frame_decoder #(.IPID_COUNT(IPID_COUNT)) u_ipid_frame_decoder (
        .clk(clk), .rst(rst), .gpio_rdata(gpio_rdata), .listen(listen),
        .id_index(id_index), .frame_ok(frame_ok), .frame_bad(frame_bad),
        .pair_sel(pair_sel), .pair_block(pair_block)
    );

    ipid_hash_engine #(.IPID_COUNT(IPID_COUNT)) u_ipid_hash_engine (
        .clk(clk), .rst(rst), .hash_start(hash_start), .pair_block(pair_block),
        .pair_sel(pair_sel), .sha_req(sha_req), .sha_ready(sha_ready),
        .sha_digest(sha_digest), .digest(digest), .hash_done(hash_done)
    );

    id_store_writer u_id_store_writer (
        .clk(clk), .rst(rst), .store_req(store_req), .store_slot(store_slot),
        .store_data(store_data), .store_done(store_done), .mem_wr(mem_wr)
    );

endmodule

`default_nettype wire

// File: verif/boot_peer_models.sv
/* GPIO peer, SHA core and secure memory models for the boot controller testbench */
`timescale 1ns/10ps
`default_nettype none

module gpio_peer_model
    import boot_link_pkg::*;
    import boot_id_pkg::*;
#(
    parameter int IPID_COUNT = 4,
    parameter int BAD_INDEX  = 2
) (
    input  logic                       clk,
    input  logic                       rst,
    input  gpio_req_t                  gpio_req,
    input  logic [7:0]                 rnd,
    input  logic [IPID_COUNT*ID_W-1:0] ids,
    output gpio_rword_t                gpio_rdata
);

    logic [IPID_COUNT-1:0] delivered;

    task automatic send_word(input logic [15:0] word);
        repeat (int'(rnd[1:0])) @(negedge clk);  // Gap before the word
        gpio_rdata.data   = word;
        gpio_rdata.strobe = 1'b1;
        @(negedge clk);
        gpio_rdata.strobe = 1'b0;
    endtask

    task automatic send_frame(input int idx);
        logic [ID_W-1:0] id;
        id = ids[idx*ID_W +: ID_W];
        send_word(FRAME_HEADER);
        for (int w = 0; w < WORDS_PER_ID; w++) begin
            send_word(id[ID_W-1-16*w -: 16]);  // Most significant word first
        end
        if (idx == BAD_INDEX && !delivered[idx]) begin
            send_word(~FRAME_TRAILER);
        end else begin
            send_word(FRAME_TRAILER);
        end
        delivered[idx] = 1'b1;
    endtask

    initial begin
        gpio_rdata = '0;
        delivered  = '0;
        forever begin
            @(negedge clk);
            if (rst && gpio_req.access && gpio_req.rw) begin
                if (gpio_req.wr_data == WAKE_CMD) begin
                    repeat (int'(rnd[2:0]) + 1) @(negedge clk);
                    gpio_rdata.wake_ack = 1'b1;  // Bus stays awake
                end else if (gpio_req.wr_data[TRIGGER_BIT]) begin
                    send_frame(int'(gpio_req.wr_data[TRIGGER_BIT-1 -: 4]));
                end
            end
        end
    end

endmodule

module sha_core_model
    import boot_id_pkg::*;
(
    input  logic            clk,
    input  sha_req_t        sha_req,
    input  logic [7:0]      rnd,
    output logic            sha_ready,
    output logic [ID_W-1:0] sha_digest
);

    initial begin
        sha_ready  = 1'b1;
        sha_digest = '0;
        forever begin
            @(negedge clk);
            if (sha_req.init || sha_req.next) begin
                // Init restarts the state, next folds both halves in
                if (sha_req.init) begin
                    sha_digest = sha_req.block[2*ID_W-1:ID_W] ^ sha_req.block[ID_W-1:0];
                end else begin
                    sha_digest = sha_digest ^ sha_req.block[2*ID_W-1:ID_W]
                                 ^ sha_req.block[ID_W-1:0];
                end
                sha_ready = 1'b0;
                repeat (int'(rnd[2:0]) % 6 + 1) @(negedge clk);
                sha_ready = 1'b1;
            end
        end
    end

endmodule

module secure_mem_model
    import boot_id_pkg::*;
(
    input logic    clk,
    input mem_wr_t mem_wr
);

    always @(posedge clk) begin
        if (mem_wr.wr_en) begin
            $display("%0t: memory write slot %0d data %h", $time, mem_wr.addr, mem_wr.data);
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_secure_boot_control.sv
/* Secure boot controller testbench: clock, reset, PUF and ID stimulus,
   reference digest, checker and watchdog */
`timescale 1ns/10ps
`default_nettype none

module tb_secure_boot_control
    import boot_link_pkg::*;
    import boot_id_pkg::*;
();

    localparam int IPID_COUNT      = 4;
    localparam int BAD_INDEX       = 2;
    localparam int WATCHDOG_CYCLES = IPID_COUNT * 3 * 40 + 400;

    logic                       clk;
    logic                       rst;
    logic                       rst_q = 1'b0;
    logic [ID_W-1:0]            cam_puf;
    logic [ID_W-1:0]            sha_puf;
    gpio_rword_t                gpio_rdata;
    gpio_req_t                  gpio_req;
    sha_req_t                   sha_req;
    logic                       sha_ready;
    logic [ID_W-1:0]            sha_digest;
    mem_wr_t                    mem_wr;
    logic                       boot_done;
    logic [31:0]                lfsr_q;
    logic [7:0]                 rnd = 8'h00;
    logic [IPID_COUNT*ID_W-1:0] ids;
    logic                       ack_q = 1'b0;
    int                         trig_exp[$];
    int                         errors;
    int                         n_trig;
    int                         n_init;
    int                         n_next;
    int                         n_wr;
    int                         n_gpio_wr;
    int                         cyc;
    int                         wr_cyc;
    bit                         done_seen;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [ID_W-1:0] lfsr_bits(input int n);
        logic [ID_W-1:0] bits;
        logic            fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            bits   = {bits[ID_W-2:0], fb};
        end
        return bits;
    endfunction

    // Expected digest: init takes the first pair, next folds in the others
    function automatic logic [ID_W-1:0] ref_digest(input logic [IPID_COUNT*ID_W-1:0] id_vec);
        logic [ID_W-1:0] acc;
        logic [ID_W-1:0] hi;
        logic [ID_W-1:0] lo;
        acc = '0;
        for (int p = 0; p < IPID_COUNT / 2; p++) begin
            hi = id_vec[(2*p+1)*ID_W +: ID_W];
            lo = id_vec[2*p*ID_W +: ID_W];
            if (p == 0) acc = hi ^ lo;
            else acc = acc ^ hi ^ lo;
        end
        return acc;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic check_gpio_write();
        logic [31:0] want;
        if (n_gpio_wr == 0) begin
            if (gpio_req.wr_data != WAKE_CMD)
                flag_error($sformatf("first GPIO write %h, expected %h", gpio_req.wr_data, WAKE_CMD));
        end else if (gpio_req.wr_data[TRIGGER_BIT]) begin
            if (!ack_q) flag_error("trigger sent before wake_ack");
            if (n_trig >= trig_exp.size()) begin
                flag_error("more triggers than expected");
            end else begin
                want = (32'd1 << TRIGGER_BIT) | (32'(trig_exp[n_trig]) << 8);
                if (gpio_req.wr_data != want)
                    flag_error($sformatf("trigger %h, expected %h", gpio_req.wr_data, want));
            end
            n_trig++;
        end else if (gpio_req.wr_data != '0) begin
            flag_error($sformatf("unexpected GPIO write %h", gpio_req.wr_data));
        end
        n_gpio_wr++;
    endtask

    task automatic check_sha_block();
        int                pair;
        logic [2*ID_W-1:0] want;
        pair = n_init + n_next;
        if (sha_req.init && pair != 0) flag_error("init on a later block");
        if (sha_req.next && n_init != 1) flag_error("next without one init before it");
        if (pair >= IPID_COUNT / 2) begin
            flag_error("more SHA blocks than ID pairs");
        end else begin
            want = {ids[(2*pair+1)*ID_W +: ID_W], ids[2*pair*ID_W +: ID_W]};
            if (sha_req.block != want) flag_error($sformatf("SHA block %0d differs from ID pair", pair));
        end
        if (sha_req.init) n_init++;
        else n_next++;
    endtask

    task automatic check_mem_write();
        if (n_wr == 0) begin
            if (mem_wr.addr != MCSE_ID_SLOT || mem_wr.data != (cam_puf ^ sha_puf))
                flag_error($sformatf("MCSE write slot %0d data %h", mem_wr.addr, mem_wr.data));
        end else if (n_wr == 1) begin
            if (mem_wr.addr != IP_ID_SLOT || mem_wr.data != ref_digest(ids))
                flag_error($sformatf("digest write slot %0d data %h", mem_wr.addr, mem_wr.data));
            if (boot_done) flag_error("boot_done high before the digest write");
        end else begin
            flag_error("memory write after the digest write");
        end
        n_wr++;
        wr_cyc = cyc;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        rnd   <= 8'(lfsr_bits(8));
        ack_q <= gpio_rdata.wake_ack;
        rst_q <= rst;
    end

    secure_boot_control #(.IPID_COUNT(IPID_COUNT)) u_secure_boot_control (
        .clk(clk), .rst(rst), .cam_puf(cam_puf), .sha_puf(sha_puf),
        .gpio_rdata(gpio_rdata), .gpio_req(gpio_req), .sha_req(sha_req),
        .sha_ready(sha_ready), .sha_digest(sha_digest), .mem_wr(mem_wr),
        .boot_done(boot_done)
    );

    gpio_peer_model #(.IPID_COUNT(IPID_COUNT), .BAD_INDEX(BAD_INDEX)) u_gpio_peer (
        .clk(clk), .rst(rst), .gpio_req(gpio_req), .rnd(rnd), .ids(ids),
        .gpio_rdata(gpio_rdata)
    );

    sha_core_model u_sha_core (
        .clk(clk), .sha_req(sha_req), .rnd(rnd), .sha_ready(sha_ready),
        .sha_digest(sha_digest)
    );

    secure_mem_model u_secure_mem (.clk(clk), .mem_wr(mem_wr));

    // Outputs change on the rising edge, so they are compared on the falling one
    always @(negedge clk) begin
        if (rst_q) begin
            cyc++;
            if (gpio_req.access && gpio_req.rw) check_gpio_write();
            if (sha_req.init || sha_req.next) check_sha_block();
            if (mem_wr.wr_en) check_mem_write();
            if (boot_done && !done_seen) begin
                done_seen = 1'b1;
                if (n_wr != 2 || cyc != wr_cyc + 2)
                    flag_error($sformatf("boot_done rose %0d cycles after write %0d",
                                         cyc - wr_cyc, n_wr));
            end
            if (done_seen && !boot_done) flag_error("boot_done fell after rising");
        end
    end

    initial begin
        rst     = 1'b0;
        lfsr_q  = 32'hba50;
        cam_puf = lfsr_bits(ID_W);
        sha_puf = lfsr_bits(ID_W);
        for (int i = 0; i < IPID_COUNT; i++) begin
            ids[i*ID_W +: ID_W] = lfsr_bits(ID_W);
            trig_exp.push_back(i);
            if (i == BAD_INDEX) trig_exp.push_back(i);  // Bad trailer, asked again
        end
        repeat (5) begin
            @(negedge clk);
            if (gpio_req.access || mem_wr.wr_en || sha_req.init || sha_req.next || boot_done)
                flag_error("control outputs not low during reset");
        end
        rst = 1'b1;
        while (!boot_done) @(negedge clk);
        repeat (20) @(negedge clk);
        if (n_trig != trig_exp.size()) flag_error($sformatf("%0d triggers seen", n_trig));
        if (n_init != 1 || n_next != IPID_COUNT / 2 - 1)
            flag_error($sformatf("%0d init and %0d next strobes", n_init, n_next));
        if (n_wr != 2) flag_error($sformatf("%0d memory writes", n_wr));
        if (!boot_done) flag_error("boot_done not held high");
        $display("errors %0d, triggers %0d, SHA blocks %0d, memory writes %0d",
                 errors, n_trig, n_init + n_next, n_wr);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: boot_done did not rise within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hw/boot_link_pkg.sv
hw/boot_id_pkg.sv
hw/ipid_frame_decoder.sv
hw/ipid_hash_engine.sv
hw/id_store_writer.sv
hw/chip_id_sequencer.sv
hw/secure_boot_control.sv
verif/boot_peer_models.sv
verif/tb_secure_boot_control.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the secure boot controller testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_secure_boot_control -f all.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"
if grep -qx "Everything OK" <<< "$out"; then
    exit 0
fi
exit 1
